// File: verilog/id_pkg.sv
// shared widths, opcode/funct7 encodings and packet structs for the decode stage
package id_pkg;

    // vector types
    typedef logic [31:0] inst_t;      // instruction word
    typedef logic [31:0] addr_t;      // instruction address
    typedef logic [31:0] reg_data_t;  // gpr or csr value
    typedef logic [4:0]  reg_addr_t;  // gpr index
    typedef logic [11:0] csr_addr_t;  // csr number

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct7 values seen on OPC_OP
    localparam logic [6:0] F7_BASE   = 7'b0000000;  // add, sll, srl ...
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // m extension

    // fetch -> decode
    typedef struct packed {
        inst_t inst;
        addr_t inst_addr;
    } fetch_pkt_t;

    // decoder result
    typedef struct packed {
        reg_addr_t   reg1_raddr;
        reg_addr_t   reg2_raddr;
        logic        reg_we;
        reg_addr_t   reg_waddr;
        csr_addr_t   csr_addr;
        logic        csr_we;
        logic        mem_req;
        logic [27:0] pad;         // always zero
    } dec_ctrl_t;

    // decode -> execute
    typedef struct packed {
        inst_t     inst;
        addr_t     inst_addr;
        reg_data_t reg1_rdata;
        reg_data_t reg2_rdata;
        reg_data_t csr_rdata;
        logic      reg_we;
        reg_addr_t reg_waddr;
        logic      csr_we;
        csr_addr_t csr_waddr;
        logic      mem_req;
    } id_ex_pkt_t;

endpackage

// File: verilog/id_decoder.sv
// combinational rv32im/zicsr field decode, gives read addresses and write controls
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::inst_t     inst_i,
    output id_pkg::dec_ctrl_t ctrl_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    id_pkg::reg_addr_t rd;
    id_pkg::reg_addr_t rs1;
    id_pkg::reg_addr_t rs2;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    always_comb begin
        ctrl_o = '0;  // anything not listed decodes to all zero

        case (opcode)
            id_pkg::OPC_OP_IMM: begin
                ctrl_o.reg1_raddr = rs1;
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.reg_waddr  = rd;
            end

            id_pkg::OPC_OP: begin
                if ((funct7 == id_pkg::F7_BASE) || (funct7 == id_pkg::F7_ALT)) begin
                    ctrl_o.reg1_raddr = rs1;
                    ctrl_o.reg2_raddr = rs2;
                    ctrl_o.reg_we     = 1'b1;
                    ctrl_o.reg_waddr  = rd;
                end else if (funct7 == id_pkg::F7_MULDIV) begin
                    ctrl_o.reg1_raddr = rs1;
                    ctrl_o.reg2_raddr = rs2;
                    ctrl_o.reg_waddr  = rd;
                    // div/rem write back later from the divider, not here
                    ctrl_o.reg_we     = ~funct3[2];
                end
            end

            id_pkg::OPC_LOAD: begin
                case (funct3)
                    3'd0, 3'd1, 3'd2, 3'd4, 3'd5: begin  // lb lh lw lbu lhu
                        ctrl_o.reg1_raddr = rs1;
                        ctrl_o.reg_we     = 1'b1;
                        ctrl_o.reg_waddr  = rd;
                        ctrl_o.mem_req    = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            id_pkg::OPC_STORE: begin
                case (funct3)
                    3'd0, 3'd1, 3'd2: begin  // sb sh sw
                        ctrl_o.reg1_raddr = rs1;
                        ctrl_o.reg2_raddr = rs2;
                        ctrl_o.mem_req    = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            id_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7: begin
                        ctrl_o.reg1_raddr = rs1;
                        ctrl_o.reg2_raddr = rs2;
                    end
                    default: begin
                    end
                endcase
            end

            id_pkg::OPC_JAL, id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
                ctrl_o.reg_we    = 1'b1;
                ctrl_o.reg_waddr = rd;
            end

            id_pkg::OPC_JALR: begin
                ctrl_o.reg1_raddr = rs1;
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.reg_waddr  = rd;
            end

            id_pkg::OPC_SYSTEM: begin
                ctrl_o.csr_addr = inst_i[31:20];  // csr number read for every system op
                case (funct3)
                    3'd1, 3'd2, 3'd3: begin  // csrrw csrrs csrrc
                        ctrl_o.reg1_raddr = rs1;
                        ctrl_o.reg_we     = 1'b1;
                        ctrl_o.reg_waddr  = rd;
                        ctrl_o.csr_we     = 1'b1;
                    end
                    3'd5, 3'd6, 3'd7: begin  // immediate forms, rs1 field is uimm
                        ctrl_o.reg_we    = 1'b1;
                        ctrl_o.reg_waddr = rd;
                        ctrl_o.csr_we    = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            default: begin
            end
        endcase
    end

    // stores have no destination register
    always_comb begin
        a_store_no_we: assert (!((opcode == id_pkg::OPC_STORE) && ctrl_o.reg_we))
            else $error("store decoded with reg_we set");
    end

endmodule

// File: verilog/id_ex_reg.sv
// one-entry decode/execute pipeline register with valid/ready handshake and flush
`timescale 1ns/1ps

module id_ex_reg (
    input  logic               clk,
    input  logic               rst_n_i,
    input  id_pkg::id_ex_pkt_t in_pkt_i,
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  logic               flush_i,
    output id_pkg::id_ex_pkt_t out_pkt_o,
    output logic               out_valid_o,
    input  logic               out_ready_i
);

    logic               valid_q;
    id_pkg::id_ex_pkt_t pkt_q;
    logic               in_fire;
    logic               out_fire;

    // a flush cycle always accepts, the item is thrown away anyway
    assign in_ready_o = !valid_q || out_ready_i || flush_i;
    assign in_fire    = in_valid_i && in_ready_o;
    assign out_fire   = valid_q && out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;  // drop held and incoming
        end else if (in_fire) begin
            valid_q <= 1'b1;
        end else if (out_fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire && !flush_i) begin
            pkt_q <= in_pkt_i;
        end
    end

    assign out_pkt_o   = pkt_q;
    assign out_valid_o = valid_q;

    // stalled packet must not move
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> $stable(out_pkt_o)
    ) else $error("out_pkt_o changed while stalled");

    a_reset_empty: assert property (
        @(posedge clk) !rst_n_i |=> !out_valid_o
    ) else $error("out_valid_o set after reset");

endmodule

// File: verilog/id_stage_top.sv
// decode stage top, joins the decoder, operand read ports and the id/ex register
`timescale 1ns/1ps

module id_stage_top (
    input  logic                clk,
    input  logic                rst_n_i,

    // from fetch
    input  id_pkg::fetch_pkt_t  in_pkt_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,

    // gpr and csr read ports, data returns in the same cycle
    output id_pkg::reg_addr_t   reg1_raddr_o,
    output id_pkg::reg_addr_t   reg2_raddr_o,
    output id_pkg::csr_addr_t   csr_raddr_o,
    input  id_pkg::reg_data_t   reg1_rdata_i,
    input  id_pkg::reg_data_t   reg2_rdata_i,
    input  id_pkg::reg_data_t   csr_rdata_i,

    input  logic                ex_jump_flag_i,  // redirect from execute

    // to execute
    output id_pkg::id_ex_pkt_t  out_pkt_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);

    id_pkg::dec_ctrl_t  dec_ctrl;
    id_pkg::id_ex_pkt_t dec_pkt;

    id_decoder u_decoder (
        .inst_i (in_pkt_i.inst),
        .ctrl_o (dec_ctrl)
    );

    assign reg1_raddr_o = dec_ctrl.reg1_raddr;
    assign reg2_raddr_o = dec_ctrl.reg2_raddr;
    assign csr_raddr_o  = dec_ctrl.csr_addr;

    always_comb begin
        dec_pkt.inst       = in_pkt_i.inst;
        dec_pkt.inst_addr  = in_pkt_i.inst_addr;
        dec_pkt.reg1_rdata = reg1_rdata_i;
        dec_pkt.reg2_rdata = reg2_rdata_i;
        dec_pkt.csr_rdata  = csr_rdata_i;
        dec_pkt.reg_we     = dec_ctrl.reg_we;
        dec_pkt.reg_waddr  = dec_ctrl.reg_waddr;
        dec_pkt.csr_we     = dec_ctrl.csr_we;
        dec_pkt.csr_waddr  = dec_ctrl.csr_addr;  // write back to the csr that was read
        dec_pkt.mem_req    = dec_ctrl.mem_req;
    end

    id_ex_reg u_id_ex (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_pkt_i    (dec_pkt),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .flush_i     (ex_jump_flag_i),
        .out_pkt_o   (out_pkt_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    // one cycle from accepted fetch to valid execute packet
    a_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (in_valid_i && in_ready_o && !ex_jump_flag_i) |=> out_valid_o
    ) else $error("accepted instruction did not reach execute");

endmodule

// File: sim/id_checker.sv
// reference decode model and in-order scoreboard that the testbench top places beside the DUT
`timescale 1ns/1ps

module id_checker (
    input  logic               clk,
    input  logic               rst_n_i,
    input  id_pkg::fetch_pkt_t in_pkt_i,
    input  logic               in_valid_i,
    input  logic               in_ready_i,
    input  id_pkg::reg_addr_t  reg1_raddr_i,
    input  id_pkg::reg_addr_t  reg2_raddr_i,
    input  id_pkg::csr_addr_t  csr_raddr_i,
    input  id_pkg::reg_data_t  reg1_rdata_i,
    input  id_pkg::reg_data_t  reg2_rdata_i,
    input  id_pkg::reg_data_t  csr_rdata_i,
    input  logic               flush_i,
    input  id_pkg::id_ex_pkt_t out_pkt_i,
    input  logic               out_valid_i,
    input  logic               out_ready_i,
    output int                 error_count_o,
    output int                 pkt_count_o,
    output int                 pending_o
);

    typedef struct packed {
        id_pkg::reg_addr_t rs1;
        id_pkg::reg_addr_t rs2;
        id_pkg::csr_addr_t csr;
        logic              we;
        id_pkg::reg_addr_t waddr;
        logic              csr_we;
        logic              mem;
    } ref_dec_t;

    id_pkg::id_ex_pkt_t exp_q[$];
    id_pkg::id_ex_pkt_t exp_pkt;
    id_pkg::id_ex_pkt_t new_pkt;
    id_pkg::id_ex_pkt_t held_pkt;
    ref_dec_t           ref_now;
    logic               exp_ready;
    logic               in_reset_d = 1'b1;
    logic               accept_d   = 1'b0;
    logic               stall_d    = 1'b0;
    int                 error_count = 0;
    int                 pkt_count   = 0;
    int                 pending     = 0;

    assign error_count_o = error_count;
    assign pkt_count_o   = pkt_count;
    assign pending_o     = pending;

    function automatic ref_dec_t ref_decode(input id_pkg::inst_t inst);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       use_rs1;
        logic       use_rs2;
        logic       has_rd;
        ref_dec_t   d;
        opc     = inst[6:0];
        f3      = inst[14:12];
        f7      = inst[31:25];
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        has_rd  = 1'b0;
        d       = '0;
        case (opc)
            id_pkg::OPC_OP_IMM, id_pkg::OPC_JALR: begin
                use_rs1 = 1'b1;
                has_rd  = 1'b1;
                d.we    = 1'b1;
            end
            id_pkg::OPC_OP: begin
                if (f7 inside {id_pkg::F7_BASE, id_pkg::F7_ALT, id_pkg::F7_MULDIV}) begin
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    has_rd  = 1'b1;
                    d.we    = !((f7 == id_pkg::F7_MULDIV) && (f3 >= 3'd4));  // div/rem
                end
            end
            id_pkg::OPC_LOAD: begin
                if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                    use_rs1 = 1'b1;
                    has_rd  = 1'b1;
                    d.we    = 1'b1;
                    d.mem   = 1'b1;
                end
            end
            id_pkg::OPC_STORE: begin
                use_rs1 = (f3 <= 3'd2);
                use_rs2 = (f3 <= 3'd2);
                d.mem   = (f3 <= 3'd2);
            end
            id_pkg::OPC_BRANCH: begin
                use_rs1 = (f3 != 3'd2) && (f3 != 3'd3);
                use_rs2 = use_rs1;
            end
            id_pkg::OPC_JAL, id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
                has_rd = 1'b1;
                d.we   = 1'b1;
            end
            id_pkg::OPC_SYSTEM: begin
                d.csr = inst[31:20];
                if ((f3 != 3'd0) && (f3 != 3'd4)) begin
                    use_rs1  = !f3[2];  // uimm forms read no register
                    has_rd   = 1'b1;
                    d.we     = 1'b1;
                    d.csr_we = 1'b1;
                end
            end
            default: begin
            end
        endcase
        d.rs1   = use_rs1 ? inst[19:15] : 5'd0;
        d.rs2   = use_rs2 ? inst[24:20] : 5'd0;
        d.waddr = has_rd ? inst[11:7] : 5'd0;
        return d;
    endfunction

    task automatic flag_error(input string msg);
        $display("Fail %0t: %s", $time, msg);
        error_count++;
    endtask

    // sampled mid-cycle so values match the next rising edge
    always @(negedge clk) begin
        ref_now = ref_decode(in_pkt_i.inst);
        if (!rst_n_i) begin
            exp_q.delete();
            in_reset_d = 1'b1;
            accept_d   = 1'b0;
            stall_d    = 1'b0;
        end else begin
            if (in_reset_d && out_valid_i)
                flag_error("out_valid_o high right after reset");
            if (accept_d && !out_valid_i)
                flag_error("accepted instruction not valid one cycle later");
            if (stall_d && (!out_valid_i || (out_pkt_i !== held_pkt)))
                flag_error("stalled output packet changed or vanished");
            if (in_valid_i && ({reg1_raddr_i, reg2_raddr_i, csr_raddr_i} !==
                               {ref_now.rs1, ref_now.rs2, ref_now.csr}))
                flag_error($sformatf("read address mismatch for inst %h: got %h/%h/%h",
                                     in_pkt_i.inst, reg1_raddr_i, reg2_raddr_i, csr_raddr_i));

            // ready when the model holds nothing, execute takes, or a flush comes
            exp_ready = (exp_q.size() == 0) || out_ready_i || flush_i;
            if (in_ready_i !== exp_ready)
                flag_error($sformatf("in_ready_o is %b, expected %b with %0d held",
                                     in_ready_i, exp_ready, exp_q.size()));

            if (out_valid_i && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    flag_error($sformatf("unexpected output packet, inst %h", out_pkt_i.inst));
                end else begin
                    exp_pkt = exp_q.pop_front();
                    pkt_count++;
                    if (out_pkt_i !== exp_pkt)
                        flag_error($sformatf("packet %0d mismatch: got %h expected %h",
                                             pkt_count, out_pkt_i, exp_pkt));
                end
            end

            if (flush_i) begin
                exp_q.delete();  // held and incoming both dropped
            end else if (in_valid_i && in_ready_i) begin
                new_pkt.inst       = in_pkt_i.inst;
                new_pkt.inst_addr  = in_pkt_i.inst_addr;
                new_pkt.reg1_rdata = reg1_rdata_i;
                new_pkt.reg2_rdata = reg2_rdata_i;
                new_pkt.csr_rdata  = csr_rdata_i;
                new_pkt.reg_we     = ref_now.we;
                new_pkt.reg_waddr  = ref_now.waddr;
                new_pkt.csr_we     = ref_now.csr_we;
                new_pkt.csr_waddr  = ref_now.csr;
                new_pkt.mem_req    = ref_now.mem;
                exp_q.push_back(new_pkt);
            end

            in_reset_d = 1'b0;
            accept_d   = in_valid_i && in_ready_i && !flush_i;
            stall_d    = out_valid_i && !out_ready_i && !flush_i;
            held_pkt   = out_pkt_i;
        end
        pending = exp_q.size();
    end

endmodule

// File: sim/tb_id_stage.sv
// simulation top that drives random fetches into the decode stage and models the register files
`timescale 1ns/1ps

module tb_id_stage;

    localparam logic [31:0] SEED           = 32'hba9f_9689;
    localparam int          RESET_CYCLES   = 16;
    localparam int          NUM_ITEMS      = 2000;
    localparam int          READY_HI_ITEMS = 200;  // first items with execute always ready
    localparam int          HOLD_TIMEOUT   = 200;
    localparam int          RUN_TIMEOUT    = 50000;
    localparam int          DRAIN_TIMEOUT  = 100;

    logic               clk;
    logic               rst_n;
    id_pkg::fetch_pkt_t in_pkt;
    logic               in_valid;
    logic               in_ready;
    id_pkg::reg_addr_t  reg1_raddr;
    id_pkg::reg_addr_t  reg2_raddr;
    id_pkg::csr_addr_t  csr_raddr;
    id_pkg::reg_data_t  reg1_rdata;
    id_pkg::reg_data_t  reg2_rdata;
    id_pkg::reg_data_t  csr_rdata;
    logic               jump;
    id_pkg::id_ex_pkt_t out_pkt;
    logic               out_valid;
    logic               out_ready;
    int                 error_count;
    int                 pkt_count;
    int                 pending;

    id_pkg::reg_data_t gpr_model [32];
    id_pkg::reg_data_t csr_model [4096];

    // zero-latency read ports
    assign reg1_rdata = gpr_model[reg1_raddr];
    assign reg2_rdata = gpr_model[reg2_raddr];
    assign csr_rdata  = csr_model[csr_raddr];

    id_stage_top UUT (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .in_pkt_i       (in_pkt),
        .in_valid_i     (in_valid),
        .in_ready_o     (in_ready),
        .reg1_raddr_o   (reg1_raddr),
        .reg2_raddr_o   (reg2_raddr),
        .csr_raddr_o    (csr_raddr),
        .reg1_rdata_i   (reg1_rdata),
        .reg2_rdata_i   (reg2_rdata),
        .csr_rdata_i    (csr_rdata),
        .ex_jump_flag_i (jump),
        .out_pkt_o      (out_pkt),
        .out_valid_o    (out_valid),
        .out_ready_i    (out_ready)
    );

    id_checker u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .in_pkt_i      (in_pkt),
        .in_valid_i    (in_valid),
        .in_ready_i    (in_ready),
        .reg1_raddr_i  (reg1_raddr),
        .reg2_raddr_i  (reg2_raddr),
        .csr_raddr_i   (csr_raddr),
        .reg1_rdata_i  (reg1_rdata),
        .reg2_rdata_i  (reg2_rdata),
        .csr_rdata_i   (csr_rdata),
        .flush_i       (jump),
        .out_pkt_i     (out_pkt),
        .out_valid_i   (out_valid),
        .out_ready_i   (out_ready),
        .error_count_o (error_count),
        .pkt_count_o   (pkt_count),
        .pending_o     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // mostly legal opcodes with random fields and now and then a raw word
    function automatic id_pkg::inst_t random_inst();
        id_pkg::inst_t w;
        int            sel;
        w   = $urandom;
        sel = $urandom_range(0, 11);
        case (sel)
            0: w[6:0] = id_pkg::OPC_OP_IMM;
            1, 2: begin
                w[6:0] = id_pkg::OPC_OP;
                case ($urandom_range(0, 3))
                    0: w[31:25] = id_pkg::F7_BASE;
                    1: w[31:25] = id_pkg::F7_ALT;
                    2: w[31:25] = id_pkg::F7_MULDIV;
                    default: begin
                    end
                endcase
            end
            3: w[6:0] = id_pkg::OPC_LOAD;
            4: w[6:0] = id_pkg::OPC_STORE;
            5: w[6:0] = id_pkg::OPC_BRANCH;
            6: w[6:0] = id_pkg::OPC_JAL;
            7: w[6:0] = id_pkg::OPC_JALR;
            8: w[6:0] = id_pkg::OPC_LUI;
            9: w[6:0] = id_pkg::OPC_AUIPC;
            10: w[6:0] = id_pkg::OPC_SYSTEM;
            default: begin
            end
        endcase
        return w;
    endfunction

    initial begin
        int   sent;
        int   cycles;
        int   hold_cycles;
        logic fired;
        logic timed_out;
        void'($urandom(SEED));
        for (int i = 0; i < 32; i++)
            gpr_model[i] = (i == 0) ? 32'd0 : $urandom;
        for (int i = 0; i < 4096; i++)
            csr_model[i] = $urandom;
        rst_n     = 1'b0;
        in_pkt    = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        jump      = 1'b0;
        sent        = 0;
        cycles      = 0;
        hold_cycles = 0;
        timed_out   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        while ((sent < NUM_ITEMS) && !timed_out) begin
            @(negedge clk);
            fired = in_valid && in_ready;  // transfer at the coming edge
            @(posedge clk);
            #1;
            cycles++;
            if (fired) begin
                sent++;
                hold_cycles = 0;
            end else if (in_valid) begin
                hold_cycles++;
            end
            if (fired || !in_valid) begin  // valid and data held until taken
                in_valid         = ($urandom_range(0, 3) != 0);
                in_pkt.inst      = random_inst();
                in_pkt.inst_addr = $urandom & 32'hffff_fffc;  // word aligned
            end
            out_ready = (sent < READY_HI_ITEMS) ? 1'b1 : ($urandom_range(0, 3) != 0);
            jump      = ($urandom_range(0, 19) == 0);
            if ((hold_cycles > HOLD_TIMEOUT) || (cycles > RUN_TIMEOUT))
                timed_out = 1'b1;
        end

        // drain what is left in the stage
        in_valid    = 1'b0;
        jump        = 1'b0;
        out_ready   = 1'b1;
        hold_cycles = 0;
        while (!timed_out && ((pending != 0) || out_valid)) begin
            @(posedge clk);
            #1;
            hold_cycles++;
            if (hold_cycles > DRAIN_TIMEOUT)
                timed_out = 1'b1;
        end
        @(negedge clk);
        #1;

        if (timed_out)
            $display("timeout: stage stopped accepting or delivering instructions");
        $display("sent %0d, checked %0d packets, %0d errors", sent, pkt_count, error_count);
        if (timed_out || (error_count != 0)) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_ex_reg.sv
verilog/id_stage_top.sv
sim/id_checker.sv
sim/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator, runs it, and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_id_stage \
    -Mdir "$BUILD_DIR" \
    -o tb_id_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/tb_id_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
